// File: source/axi_pkg.sv
package axi_pkg;

    // AXI response codes, EXOKAY and DECERR are never produced here
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

    // write channel sequencing, shared by the bridge and the slave
    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_ADDR = 2'd1,
        WR_DATA = 2'd2,
        WR_RESP = 2'd3
    } wr_state_t;

    // read channel sequencing
    typedef enum logic [1:0] {
        RD_IDLE = 2'd0,
        RD_ADDR = 2'd1,
        RD_DATA = 2'd2
    } rd_state_t;

endpackage

// File: source/axi_lite_master.sv
module axi_lite_master #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                      aclk,
    input  logic                      areset_n,

    // cpu write request
    input  logic                      cpu_w_valid_i,
    input  logic [ADDR_WIDTH-1:0]     cpu_w_addr_i,
    input  logic [DATA_WIDTH-1:0]     cpu_w_data_i,
    input  logic [DATA_WIDTH/8-1:0]   cpu_w_strb_i,
    output logic                      cpu_w_ready_o,
    output logic                      cpu_w_err_o,

    // cpu read request
    input  logic                      cpu_r_valid_i,
    input  logic [ADDR_WIDTH-1:0]     cpu_r_addr_i,
    output logic                      cpu_r_ready_o,
    output logic [DATA_WIDTH-1:0]     cpu_r_data_o,
    output logic                      cpu_r_err_o,

    // aw channel
    output logic                      axi_aw_valid_o,
    input  logic                      axi_aw_ready_i,
    output logic [ADDR_WIDTH-1:0]     axi_aw_addr_o,

    // w channel
    output logic                      axi_w_valid_o,
    input  logic                      axi_w_ready_i,
    output logic [DATA_WIDTH-1:0]     axi_w_data_o,
    output logic [DATA_WIDTH/8-1:0]   axi_w_strb_o,

    // b channel
    input  logic                      axi_b_valid_i,
    output logic                      axi_b_ready_o,
    input  axi_pkg::resp_t            axi_b_resp_i,

    // ar channel
    output logic                      axi_ar_valid_o,
    input  logic                      axi_ar_ready_i,
    output logic [ADDR_WIDTH-1:0]     axi_ar_addr_o,

    // r channel
    input  logic                      axi_r_valid_i,
    output logic                      axi_r_ready_o,
    input  logic [DATA_WIDTH-1:0]     axi_r_data_i,
    input  axi_pkg::resp_t            axi_r_resp_i
);

    axi_pkg::wr_state_t wr_state;
    axi_pkg::rd_state_t rd_state;

    logic [ADDR_WIDTH-1:0]   wr_addr_q;
    logic [DATA_WIDTH-1:0]   wr_data_q;
    logic [DATA_WIDTH/8-1:0] wr_strb_q;
    logic [ADDR_WIDTH-1:0]   rd_addr_q;

    assign axi_aw_valid_o = (wr_state == axi_pkg::WR_ADDR);
    assign axi_aw_addr_o  = wr_addr_q;
    assign axi_w_valid_o  = (wr_state == axi_pkg::WR_DATA);
    assign axi_w_data_o   = wr_data_q;
    assign axi_w_strb_o   = wr_strb_q;
    assign axi_b_ready_o  = (wr_state == axi_pkg::WR_RESP);

    // done pulses in the cycle of the response transfer
    assign cpu_w_ready_o = axi_b_ready_o & axi_b_valid_i;
    assign cpu_w_err_o   = cpu_w_ready_o & (axi_b_resp_i != axi_pkg::OKAY);

    assign axi_ar_valid_o = (rd_state == axi_pkg::RD_ADDR);
    assign axi_ar_addr_o  = rd_addr_q;
    assign axi_r_ready_o  = (rd_state == axi_pkg::RD_DATA);

    assign cpu_r_ready_o = axi_r_ready_o & axi_r_valid_i;
    assign cpu_r_data_o  = axi_r_data_i;
    assign cpu_r_err_o   = cpu_r_ready_o & (axi_r_resp_i != axi_pkg::OKAY);

    // request fields are held here so the channel payload cannot move
    always_ff @(posedge aclk) begin
        if (wr_state == axi_pkg::WR_IDLE && cpu_w_valid_i) begin
            wr_addr_q <= cpu_w_addr_i;
            wr_data_q <= cpu_w_data_i;
            wr_strb_q <= cpu_w_strb_i;
        end
        if (rd_state == axi_pkg::RD_IDLE && cpu_r_valid_i) begin
            rd_addr_q <= cpu_r_addr_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            wr_state <= axi_pkg::WR_IDLE;
        end else begin
            case (wr_state)
                axi_pkg::WR_IDLE: begin
                    if (cpu_w_valid_i) wr_state <= axi_pkg::WR_ADDR;
                end
                axi_pkg::WR_ADDR: begin
                    if (axi_aw_ready_i) wr_state <= axi_pkg::WR_DATA;
                end
                axi_pkg::WR_DATA: begin
                    if (axi_w_ready_i) wr_state <= axi_pkg::WR_RESP;
                end
                axi_pkg::WR_RESP: begin
                    if (axi_b_valid_i) wr_state <= axi_pkg::WR_IDLE;
                end
                default: wr_state <= axi_pkg::WR_IDLE;
            endcase
        end
    end

    // read side has its own state register
    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            rd_state <= axi_pkg::RD_IDLE;
        end else begin
            case (rd_state)
                axi_pkg::RD_IDLE: begin
                    if (cpu_r_valid_i) rd_state <= axi_pkg::RD_ADDR;
                end
                axi_pkg::RD_ADDR: begin
                    if (axi_ar_ready_i) rd_state <= axi_pkg::RD_DATA;
                end
                axi_pkg::RD_DATA: begin
                    if (axi_r_valid_i) rd_state <= axi_pkg::RD_IDLE;
                end
                default: rd_state <= axi_pkg::RD_IDLE;
            endcase
        end
    end

endmodule

// File: source/axi_lite_sram.sv
module axi_lite_sram #(
    parameter int ADDR_WIDTH     = 32,
    parameter int DATA_WIDTH     = 32,
    parameter int MEM_WORDS_LOG2 = 8,
    parameter int RESP_LATENCY   = 3
) (
    input  logic                      aclk,
    input  logic                      areset_n,

    input  logic                      axi_aw_valid_i,
    output logic                      axi_aw_ready_o,
    input  logic [ADDR_WIDTH-1:0]     axi_aw_addr_i,

    input  logic                      axi_w_valid_i,
    output logic                      axi_w_ready_o,
    input  logic [DATA_WIDTH-1:0]     axi_w_data_i,
    input  logic [DATA_WIDTH/8-1:0]   axi_w_strb_i,

    output logic                      axi_b_valid_o,
    input  logic                      axi_b_ready_i,
    output axi_pkg::resp_t            axi_b_resp_o,

    input  logic                      axi_ar_valid_i,
    output logic                      axi_ar_ready_o,
    input  logic [ADDR_WIDTH-1:0]     axi_ar_addr_i,

    output logic                      axi_r_valid_o,
    input  logic                      axi_r_ready_i,
    output logic [DATA_WIDTH-1:0]     axi_r_data_o,
    output axi_pkg::resp_t            axi_r_resp_o
);

    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int OFFSET     = $clog2(STRB_WIDTH);
    localparam int MEM_WORDS  = 1 << MEM_WORDS_LOG2;
    localparam int CNT_WIDTH  = (RESP_LATENCY > 0) ? $clog2(RESP_LATENCY + 1) : 1;

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    axi_pkg::wr_state_t    wr_state;
    axi_pkg::rd_state_t    rd_state;
    logic [ADDR_WIDTH-1:0] wr_addr_q;
    logic [ADDR_WIDTH-1:0] rd_addr_q;
    logic [CNT_WIDTH-1:0]  wr_cnt;
    logic [CNT_WIDTH-1:0]  rd_cnt;
    logic                  wr_ok;
    logic                  rd_ok;
    logic                  w_fire;

    // word index must fit below the array depth
    function automatic logic in_range(input logic [ADDR_WIDTH-1:0] addr);
        return addr[ADDR_WIDTH-1:OFFSET+MEM_WORDS_LOG2] == '0;
    endfunction

    assign wr_ok  = in_range(wr_addr_q);
    assign rd_ok  = in_range(rd_addr_q);
    assign w_fire = axi_w_valid_i & axi_w_ready_o;

    assign axi_aw_ready_o = (wr_state == axi_pkg::WR_IDLE);
    assign axi_w_ready_o  = (wr_state == axi_pkg::WR_DATA);
    assign axi_b_valid_o  = (wr_state == axi_pkg::WR_RESP) && (wr_cnt == '0);
    assign axi_b_resp_o   = wr_ok ? axi_pkg::OKAY : axi_pkg::SLVERR;

    assign axi_ar_ready_o = (rd_state == axi_pkg::RD_IDLE);
    assign axi_r_valid_o  = (rd_state == axi_pkg::RD_DATA) && (rd_cnt == '0);
    assign axi_r_resp_o   = rd_ok ? axi_pkg::OKAY : axi_pkg::SLVERR;
    assign axi_r_data_o   = rd_ok ? mem[rd_addr_q[OFFSET +: MEM_WORDS_LOG2]] : '0;

    // byte lanes, out of range writes are dropped
    always_ff @(posedge aclk) begin
        if (w_fire && wr_ok) begin
            for (int i = 0; i < STRB_WIDTH; i++) begin
                if (axi_w_strb_i[i]) begin
                    mem[wr_addr_q[OFFSET +: MEM_WORDS_LOG2]][i*8 +: 8] <= axi_w_data_i[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (axi_aw_valid_i && axi_aw_ready_o) wr_addr_q <= axi_aw_addr_i;
        if (axi_ar_valid_i && axi_ar_ready_o) rd_addr_q <= axi_ar_addr_i;
    end

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            wr_state <= axi_pkg::WR_IDLE;
            wr_cnt   <= '0;
        end else begin
            case (wr_state)
                axi_pkg::WR_IDLE: begin
                    if (axi_aw_valid_i) wr_state <= axi_pkg::WR_DATA;
                end
                axi_pkg::WR_DATA: begin
                    if (axi_w_valid_i) begin
                        wr_state <= axi_pkg::WR_RESP;
                        wr_cnt   <= CNT_WIDTH'(RESP_LATENCY);
                    end
                end
                axi_pkg::WR_RESP: begin
                    // latency countdown, then hold b until accepted
                    if (wr_cnt != '0) begin
                        wr_cnt <= wr_cnt - 1'b1;
                    end else if (axi_b_ready_i) begin
                        wr_state <= axi_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= axi_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            rd_state <= axi_pkg::RD_IDLE;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                axi_pkg::RD_IDLE: begin
                    if (axi_ar_valid_i) begin
                        rd_state <= axi_pkg::RD_DATA;
                        rd_cnt   <= CNT_WIDTH'(RESP_LATENCY);
                    end
                end
                axi_pkg::RD_DATA: begin
                    if (rd_cnt != '0) begin
                        rd_cnt <= rd_cnt - 1'b1;
                    end else if (axi_r_ready_i) begin
                        rd_state <= axi_pkg::RD_IDLE;
                    end
                end
                default: rd_state <= axi_pkg::RD_IDLE;
            endcase
        end
    end

endmodule

// File: source/axi_mem_subsystem.sv
module axi_mem_subsystem #(
    parameter int ADDR_WIDTH     = 32,
    parameter int DATA_WIDTH     = 32,
    parameter int MEM_WORDS_LOG2 = 8,
    parameter int RESP_LATENCY   = 3
) (
    input  logic                      aclk,
    input  logic                      areset_n,

    input  logic                      cpu_w_valid_i,
    input  logic [ADDR_WIDTH-1:0]     cpu_w_addr_i,
    input  logic [DATA_WIDTH-1:0]     cpu_w_data_i,
    input  logic [DATA_WIDTH/8-1:0]   cpu_w_strb_i,
    output logic                      cpu_w_ready_o,
    output logic                      cpu_w_err_o,

    input  logic                      cpu_r_valid_i,
    input  logic [ADDR_WIDTH-1:0]     cpu_r_addr_i,
    output logic                      cpu_r_ready_o,
    output logic [DATA_WIDTH-1:0]     cpu_r_data_o,
    output logic                      cpu_r_err_o
);

    // axi4-lite link between bridge and sram
    logic                    axi_aw_valid;
    logic                    axi_aw_ready;
    logic [ADDR_WIDTH-1:0]   axi_aw_addr;
    logic                    axi_w_valid;
    logic                    axi_w_ready;
    logic [DATA_WIDTH-1:0]   axi_w_data;
    logic [DATA_WIDTH/8-1:0] axi_w_strb;
    logic                    axi_b_valid;
    logic                    axi_b_ready;
    axi_pkg::resp_t          axi_b_resp;
    logic                    axi_ar_valid;
    logic                    axi_ar_ready;
    logic [ADDR_WIDTH-1:0]   axi_ar_addr;
    logic                    axi_r_valid;
    logic                    axi_r_ready;
    logic [DATA_WIDTH-1:0]   axi_r_data;
    axi_pkg::resp_t          axi_r_resp;

    axi_lite_master #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) axi_lite_master_inst (
        .aclk           (aclk),
        .areset_n       (areset_n),
        .cpu_w_valid_i  (cpu_w_valid_i),
        .cpu_w_addr_i   (cpu_w_addr_i),
        .cpu_w_data_i   (cpu_w_data_i),
        .cpu_w_strb_i   (cpu_w_strb_i),
        .cpu_w_ready_o  (cpu_w_ready_o),
        .cpu_w_err_o    (cpu_w_err_o),
        .cpu_r_valid_i  (cpu_r_valid_i),
        .cpu_r_addr_i   (cpu_r_addr_i),
        .cpu_r_ready_o  (cpu_r_ready_o),
        .cpu_r_data_o   (cpu_r_data_o),
        .cpu_r_err_o    (cpu_r_err_o),
        .axi_aw_valid_o (axi_aw_valid),
        .axi_aw_ready_i (axi_aw_ready),
        .axi_aw_addr_o  (axi_aw_addr),
        .axi_w_valid_o  (axi_w_valid),
        .axi_w_ready_i  (axi_w_ready),
        .axi_w_data_o   (axi_w_data),
        .axi_w_strb_o   (axi_w_strb),
        .axi_b_valid_i  (axi_b_valid),
        .axi_b_ready_o  (axi_b_ready),
        .axi_b_resp_i   (axi_b_resp),
        .axi_ar_valid_o (axi_ar_valid),
        .axi_ar_ready_i (axi_ar_ready),
        .axi_ar_addr_o  (axi_ar_addr),
        .axi_r_valid_i  (axi_r_valid),
        .axi_r_ready_o  (axi_r_ready),
        .axi_r_data_i   (axi_r_data),
        .axi_r_resp_i   (axi_r_resp)
    );

    axi_lite_sram #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .DATA_WIDTH     (DATA_WIDTH),
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
        .RESP_LATENCY   (RESP_LATENCY)
    ) axi_lite_sram_inst (
        .aclk           (aclk),
        .areset_n       (areset_n),
        .axi_aw_valid_i (axi_aw_valid),
        .axi_aw_ready_o (axi_aw_ready),
        .axi_aw_addr_i  (axi_aw_addr),
        .axi_w_valid_i  (axi_w_valid),
        .axi_w_ready_o  (axi_w_ready),
        .axi_w_data_i   (axi_w_data),
        .axi_w_strb_i   (axi_w_strb),
        .axi_b_valid_o  (axi_b_valid),
        .axi_b_ready_i  (axi_b_ready),
        .axi_b_resp_o   (axi_b_resp),
        .axi_ar_valid_i (axi_ar_valid),
        .axi_ar_ready_o (axi_ar_ready),
        .axi_ar_addr_i  (axi_ar_addr),
        .axi_r_valid_o  (axi_r_valid),
        .axi_r_ready_i  (axi_r_ready),
        .axi_r_data_o   (axi_r_data),
        .axi_r_resp_o   (axi_r_resp)
    );

endmodule

// File: verif/axi_mem_subsystem_checker.sv
module axi_mem_subsystem_checker #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input logic                    aclk,
    input logic                    areset_n,
    input logic                    cpu_w_valid_i,
    input logic                    cpu_w_ready_i,
    input logic                    aw_valid_i,
    input logic                    aw_ready_i,
    input logic [ADDR_WIDTH-1:0]   aw_addr_i,
    input logic                    w_valid_i,
    input logic                    w_ready_i,
    input logic [DATA_WIDTH-1:0]   w_data_i,
    input logic [DATA_WIDTH/8-1:0] w_strb_i,
    input logic                    b_valid_i,
    input logic                    b_ready_i,
    input axi_pkg::resp_t          b_resp_i,
    input logic                    ar_valid_i,
    input logic                    ar_ready_i,
    input logic [ADDR_WIDTH-1:0]   ar_addr_i,
    input logic                    r_valid_i,
    input logic                    r_ready_i,
    input logic [DATA_WIDTH-1:0]   r_data_i,
    input axi_pkg::resp_t          r_resp_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic w_pending;

    // set by a w transfer, cleared by the matching b transfer
    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            w_pending <= 1'b0;
        end else if (w_valid_i && w_ready_i) begin
            w_pending <= 1'b1;
        end else if (b_valid_i && b_ready_i) begin
            w_pending <= 1'b0;
        end
    end

    aw_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i))
        else $error("aw valid or address changed before the transfer");

    w_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_data_i) && $stable(w_strb_i))
        else $error("w valid or payload changed before the transfer");

    b_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
        else $error("b valid or response changed before the transfer");

    ar_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
        else $error("ar valid or address changed before the transfer");

    r_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_resp_i))
        else $error("r valid or payload changed before the transfer");

    w_done_with_request: assert property (@(posedge aclk) disable iff (!areset_n)
        cpu_w_ready_i |-> cpu_w_valid_i)
        else $error("write done pulse without a pending write request");

    b_after_w: assert property (@(posedge aclk) disable iff (!areset_n)
        b_valid_i |-> w_pending)
        else $error("b valid without an earlier w transfer");

endmodule

bind axi_mem_subsystem axi_mem_subsystem_checker #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
) axi_mem_subsystem_checker_inst (
    .aclk          (aclk),
    .areset_n      (areset_n),
    .cpu_w_valid_i (cpu_w_valid_i),
    .cpu_w_ready_i (cpu_w_ready_o),
    .aw_valid_i    (axi_aw_valid),
    .aw_ready_i    (axi_aw_ready),
    .aw_addr_i     (axi_aw_addr),
    .w_valid_i     (axi_w_valid),
    .w_ready_i     (axi_w_ready),
    .w_data_i      (axi_w_data),
    .w_strb_i      (axi_w_strb),
    .b_valid_i     (axi_b_valid),
    .b_ready_i     (axi_b_ready),
    .b_resp_i      (axi_b_resp),
    .ar_valid_i    (axi_ar_valid),
    .ar_ready_i    (axi_ar_ready),
    .ar_addr_i     (axi_ar_addr),
    .r_valid_i     (axi_r_valid),
    .r_ready_i     (axi_r_ready),
    .r_data_i      (axi_r_data),
    .r_resp_i      (axi_r_resp)
);

// File: verif/axi_mem_subsystem_tb.sv
module axi_mem_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int MEM_WORDS_LOG2 = 8;
    localparam int RESP_LATENCY   = 3;
    localparam int STRB_WIDTH     = DATA_WIDTH / 8;
    localparam int BYTE_SHIFT     = $clog2(STRB_WIDTH);

    // working set of 32 words, 8 words apart
    localparam int WORK_WORDS  = 32;
    localparam int RANDOM_OPS  = 200;
    localparam int OP_COUNT    = WORK_WORDS + 20 + RANDOM_OPS;
    localparam int CYCLE_LIMIT = OP_COUNT * (10 + 2 * RESP_LATENCY) * 2;

    logic                  aclk = 1'b0;
    logic                  areset_n;
    logic                  cpu_w_valid;
    logic [ADDR_WIDTH-1:0] cpu_w_addr;
    logic [DATA_WIDTH-1:0] cpu_w_data;
    logic [STRB_WIDTH-1:0] cpu_w_strb;
    logic                  cpu_w_ready;
    logic                  cpu_w_err;
    logic                  cpu_r_valid;
    logic [ADDR_WIDTH-1:0] cpu_r_addr;
    logic                  cpu_r_ready;
    logic [DATA_WIDTH-1:0] cpu_r_data;
    logic                  cpu_r_err;

    logic [7:0]            model_mem [logic [ADDR_WIDTH-1:0]];
    logic [31:0]           lcg_state = 32'h482c_de97;
    int                    cycle_count = 0;

    axi_mem_subsystem #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .DATA_WIDTH     (DATA_WIDTH),
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
        .RESP_LATENCY   (RESP_LATENCY)
    ) axi_mem_subsystem_inst (
        .aclk          (aclk),
        .areset_n      (areset_n),
        .cpu_w_valid_i (cpu_w_valid),
        .cpu_w_addr_i  (cpu_w_addr),
        .cpu_w_data_i  (cpu_w_data),
        .cpu_w_strb_i  (cpu_w_strb),
        .cpu_w_ready_o (cpu_w_ready),
        .cpu_w_err_o   (cpu_w_err),
        .cpu_r_valid_i (cpu_r_valid),
        .cpu_r_addr_i  (cpu_r_addr),
        .cpu_r_ready_o (cpu_r_ready),
        .cpu_r_data_o  (cpu_r_data),
        .cpu_r_err_o   (cpu_r_err)
    );

    always #10 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: no completion within %0d clock cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // word index has to stay below the slave depth
    function automatic logic in_range(input logic [ADDR_WIDTH-1:0] addr);
        return (addr >> BYTE_SHIFT) < (ADDR_WIDTH'(1) << MEM_WORDS_LOG2);
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] work_addr(input logic [4:0] idx);
        return ADDR_WIDTH'(idx) << (BYTE_SHIFT + 3);
    endfunction

    // lowest word index past the end, plus random upper bits
    function automatic logic [ADDR_WIDTH-1:0] oor_addr(input logic [ADDR_WIDTH-1:0] r);
        return (ADDR_WIDTH'(1) << (MEM_WORDS_LOG2 + BYTE_SHIFT))
            | (r & ~ADDR_WIDTH'(STRB_WIDTH - 1));
    endfunction

    function automatic void model_store(input logic [ADDR_WIDTH-1:0] addr,
                                        input logic [DATA_WIDTH-1:0] data,
                                        input logic [STRB_WIDTH-1:0] strb);
        if (in_range(addr)) begin
            for (int i = 0; i < STRB_WIDTH; i++) begin
                if (strb[i]) model_mem[addr + ADDR_WIDTH'(i)] = data[i*8 +: 8];
            end
        end
    endfunction

    function automatic logic [DATA_WIDTH-1:0] model_load(input logic [ADDR_WIDTH-1:0] addr);
        logic [DATA_WIDTH-1:0] value;
        value = '0;
        if (in_range(addr)) begin
            for (int i = 0; i < STRB_WIDTH; i++) begin
                value[i*8 +: 8] = model_mem[addr + ADDR_WIDTH'(i)];
            end
        end
        return value;
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic send_write(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] data,
                              input logic [STRB_WIDTH-1:0] strb, output logic err);
        @(negedge aclk);
        cpu_w_valid = 1'b1;
        cpu_w_addr  = addr;
        cpu_w_data  = data;
        cpu_w_strb  = strb;
        // done pulse sampled mid-cycle, valid held through its edge
        do begin
            @(negedge aclk);
        end while (!cpu_w_ready);
        err = cpu_w_err;
        @(negedge aclk);
        cpu_w_valid = 1'b0;
    endtask

    task automatic send_read(input logic [ADDR_WIDTH-1:0] addr,
                             output logic [DATA_WIDTH-1:0] data, output logic err);
        @(negedge aclk);
        cpu_r_valid = 1'b1;
        cpu_r_addr  = addr;
        do begin
            @(negedge aclk);
        end while (!cpu_r_ready);
        data = cpu_r_data;
        err  = cpu_r_err;
        @(negedge aclk);
        cpu_r_valid = 1'b0;
    endtask

    task automatic write_and_check(input string name, input logic [ADDR_WIDTH-1:0] addr,
                                   input logic [DATA_WIDTH-1:0] data,
                                   input logic [STRB_WIDTH-1:0] strb);
        logic err;
        send_write(addr, data, strb, err);
        compare({name, " write err"}, 64'(!in_range(addr)), 64'(err));
        model_store(addr, data, strb);
    endtask

    task automatic read_and_check(input string name, input logic [ADDR_WIDTH-1:0] addr);
        logic                  err;
        logic [DATA_WIDTH-1:0] data;
        send_read(addr, data, err);
        compare({name, " read err"}, 64'(!in_range(addr)), 64'(err));
        compare({name, " read data"}, 64'(model_load(addr)), 64'(data));
    endtask

    initial begin
        logic [ADDR_WIDTH-1:0] r;
        logic [DATA_WIDTH-1:0] data;
        logic [4:0]            rd_idx;
        logic [4:0]            wr_idx;
        logic [ADDR_WIDTH-1:0] alias_addr;

        areset_n    = 1'b0;
        cpu_w_valid = 1'b0;
        cpu_w_addr  = '0;
        cpu_w_data  = '0;
        cpu_w_strb  = '0;
        cpu_r_valid = 1'b0;
        cpu_r_addr  = '0;
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        areset_n = 1'b1;

        repeat (8) begin
            @(negedge aclk);
            compare("idle w_ready", 64'd0, 64'(cpu_w_ready));
            compare("idle r_ready", 64'd0, 64'(cpu_r_ready));
        end

        // every read below hits a word with a known value
        for (int i = 0; i < WORK_WORDS; i++) begin
            write_and_check("fill", work_addr(5'(i)), next_random(), '1);
        end

        write_and_check("full strobe", work_addr(5'd3), 32'hcafe_f00d, '1);
        read_and_check("full strobe", work_addr(5'd3));

        write_and_check("partial strobe", work_addr(5'd4), 32'h1122_3344, 4'b0101);
        read_and_check("partial strobe", work_addr(5'd4));
        write_and_check("partial strobe", work_addr(5'd4), 32'ha5a5_5a5a, 4'b1000);
        read_and_check("partial strobe", work_addr(5'd4));

        // same low bits as word 6, only the upper bits are out of range
        alias_addr = oor_addr(work_addr(5'd6));
        write_and_check("out of range", alias_addr, 32'hdead_beef, '1);
        read_and_check("out of range", alias_addr);
        read_and_check("alias unchanged", work_addr(5'd6));

        fork
            write_and_check("overlap", work_addr(5'd10), 32'h0bad_f00d, '1);
            read_and_check("overlap", work_addr(5'd11));
        join
        read_and_check("overlap readback", work_addr(5'd10));

        for (int n = 0; n < RANDOM_OPS; n++) begin
            r    = next_random();
            data = next_random();
            case (r[31:30])
                2'd0: write_and_check("random", work_addr(r[29:25]), data, r[24:21]);
                2'd1: read_and_check("random", work_addr(r[29:25]));
                2'd2: begin
                    rd_idx = r[29:25];
                    wr_idx = rd_idx ^ (r[20:16] | 5'd1);
                    fork
                        write_and_check("random overlap", work_addr(wr_idx), data, r[24:21]);
                        read_and_check("random overlap", work_addr(rd_idx));
                    join
                end
                default: begin
                    if (r[16]) begin
                        write_and_check("random oor", oor_addr(next_random()), data, r[24:21]);
                    end else begin
                        read_and_check("random oor", oor_addr(next_random()));
                    end
                end
            endcase
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// File: build.f
source/axi_pkg.sv
source/axi_lite_master.sv
source/axi_lite_sram.sv
source/axi_mem_subsystem.sv
verif/axi_mem_subsystem_checker.sv
verif/axi_mem_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# build and run the simulation, the result is read from the printed output
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module axi_mem_subsystem_tb -o axi_mem_subsystem_sim
status=0
output=$(./obj_dir/axi_mem_subsystem_sim 2>&1) || status=$?
printf '%s\n' "$output"
[ "$status" -eq 0 ]
printf '%s\n' "$output" | grep -F -x -q '** PASS **'
